/* rtl/ext_periph_pkg.sv */
// Address map, FIFO register offsets and bus widths
// Packed union giving raw and field views of a bus address
package ext_periph_pkg;

  // Register bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Address fields
  localparam int SLOT_W = 4;
  localparam int OFFSET_W = 10;

  // Peripheral slots
  localparam logic [SLOT_W-1:0] MEM_SLOT = 4'd0;
  localparam logic [SLOT_W-1:0] FIFO_SLOT = 4'd1;

  // FIFO register word offsets
  localparam logic [OFFSET_W-1:0] FIFO_DATA_OFS = 10'd0;
  localparam logic [OFFSET_W-1:0] FIFO_LEVEL_OFS = 10'd1;
  localparam logic [OFFSET_W-1:0] FIFO_WMARK_OFS = 10'd2;

  // Same address word, either raw or split into fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [ADDR_W-SLOT_W-OFFSET_W-3:0] unused;
      logic [SLOT_W-1:0] slot;
      logic [OFFSET_W-1:0] offset;
      logic [1:0] byte_sel;
    } fld;
  } periph_addr_u;

endpackage

/* rtl/reg_bus_if.sv */
// Register bus with valid/ready handshake
// Host and device modports
interface reg_bus_if;
  import ext_periph_pkg::*;

  // Request, held by the host until ready
  logic valid;
  logic write;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;

  // Response, valid in the single ready cycle
  logic ready;
  logic [DATA_W-1:0] rdata;
  logic error;

  modport host(
    output valid, write, addr, wdata, wstrb,
    input ready, rdata, error
  );

  modport device(
    input valid, write, addr, wdata, wstrb,
    output ready, rdata, error
  );

endinterface

/* rtl/power_switch_model.sv */
// Switch-cell model delaying each domain request into its acknowledge
module power_switch_model #(
  parameter int DOMAINS = 4,
  parameter int SWITCH_ACK_LATENCY = 15
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic [DOMAINS-1:0] switch_n_i,
  output logic [DOMAINS-1:0] switch_ack_n_o
);

  logic [DOMAINS-1:0] pipe_q [SWITCH_ACK_LATENCY];

  // Ones mean switched off until real requests reach the end
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        pipe_q[i] <= '1;
      end
    end else begin
      pipe_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = pipe_q[SWITCH_ACK_LATENCY-1];

endmodule

/* rtl/slow_memory.sv */
// Word memory with byte-strobe writes
// Response latency of 1 to 8 cycles drawn from an LFSR
module slow_memory #(
  parameter int MEM_WORDS = 256
) (
  input  logic clk_i,
  input  logic rst_i,
  reg_bus_if.device bus
);
  import ext_periph_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  periph_addr_u addr;
  logic [IDX_W-1:0] idx;
  logic [7:0] lfsr_q;
  logic busy_q;
  logic [3:0] cnt_q;
  logic done;

  assign addr.raw = bus.addr;
  assign idx = addr.fld.offset[IDX_W-1:0];
  assign done = busy_q && (cnt_q == 4'd1);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= 8'hA5;
      busy_q <= 1'b0;
      cnt_q <= '0;
    end else begin
      // x^8 + x^6 + x^5 + x^4 + 1
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      if (!busy_q && bus.valid) begin
        busy_q <= 1'b1;
        cnt_q <= {1'b0, lfsr_q[2:0]} + 4'd1;
      end else if (done) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 4'd1;
      end
    end
  end

  // Write lands on the completing edge
  always_ff @(posedge clk_i) begin
    if (done && bus.write) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (bus.wstrb[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  assign bus.ready = done;
  assign bus.rdata = mem[idx];
  assign bus.error = 1'b0;

endmodule

/* rtl/iffifo.sv */
// Register-mapped FIFO with level and watermark registers
// DMA-slot status and watermark interrupt outputs
module iffifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic clk_i,
  input  logic rst_i,
  reg_bus_if.device bus,
  output logic in_ready_o,
  output logic out_valid_o,
  output logic intr_o
);
  import ext_periph_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int LVL_W = PTR_W + 1;

  logic [DATA_W-1:0] buf_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [LVL_W-1:0] level_q, wmark_q;
  logic ready_q, error_q;
  logic [DATA_W-1:0] rdata_q;
  periph_addr_u addr;
  logic access, full, empty, push, pop, bad, wmark_wr;
  logic [DATA_W-1:0] rd_value;

  assign addr.raw = bus.addr;
  assign access = bus.valid && !ready_q;
  assign full = (level_q == LVL_W'(FIFO_DEPTH));
  assign empty = (level_q == '0);

  always_comb begin
    push = 1'b0;
    pop = 1'b0;
    bad = 1'b0;
    wmark_wr = 1'b0;
    rd_value = '0;
    case (addr.fld.offset)
      FIFO_DATA_OFS: begin
        push = bus.write && !full;
        pop = !bus.write && !empty;
        bad = bus.write ? full : empty;
        rd_value = pop ? buf_q[rd_ptr_q] : '0;
      end
      FIFO_LEVEL_OFS: begin
        bad = bus.write;
        rd_value = bus.write ? '0 : DATA_W'(level_q);
      end
      FIFO_WMARK_OFS: begin
        wmark_wr = bus.write;
        rd_value = bus.write ? '0 : DATA_W'(wmark_q);
      end
      default: bad = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q <= '0;
      wmark_q <= '0;
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= access;
      error_q <= access && bad;
      if (access && push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        level_q <= level_q + 1'b1;
      end
      if (access && pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        level_q <= level_q - 1'b1;
      end
      if (access && wmark_wr) wmark_q <= bus.wdata[LVL_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && push) buf_q[wr_ptr_q] <= bus.wdata;
    if (access) rdata_q <= rd_value;
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;
  assign bus.error = error_q;
  assign in_ready_o = !full;
  assign out_valid_o = !empty;
  assign intr_o = (wmark_q != '0) && (level_q >= wmark_q);

endmodule

/* rtl/reg_demux.sv */
// Register bus demultiplexer decoding the slot field
// Unmapped slots answer with a one-cycle error response
module reg_demux (
  input  logic clk_i,
  input  logic rst_i,
  reg_bus_if.device bus_in,
  reg_bus_if.host mem_bus,
  reg_bus_if.host fifo_bus
);
  import ext_periph_pkg::*;

  periph_addr_u addr;
  logic sel_mem;
  logic sel_fifo;
  logic unmapped;
  logic err_q;

  assign addr.raw = bus_in.addr;
  assign sel_mem = (addr.fld.slot == MEM_SLOT);
  assign sel_fifo = (addr.fld.slot == FIFO_SLOT);
  assign unmapped = !sel_mem && !sel_fifo;

  // Valid only goes to the addressed peripheral
  assign mem_bus.valid = bus_in.valid && sel_mem;
  assign mem_bus.write = bus_in.write;
  assign mem_bus.addr = bus_in.addr;
  assign mem_bus.wdata = bus_in.wdata;
  assign mem_bus.wstrb = bus_in.wstrb;

  assign fifo_bus.valid = bus_in.valid && sel_fifo;
  assign fifo_bus.write = bus_in.write;
  assign fifo_bus.addr = bus_in.addr;
  assign fifo_bus.wdata = bus_in.wdata;
  assign fifo_bus.wstrb = bus_in.wstrb;

  // Error completion one cycle after an unmapped access is seen
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_in.valid && unmapped && !err_q;
    end
  end

  assign bus_in.ready = sel_mem  ? mem_bus.ready  :
                        sel_fifo ? fifo_bus.ready : err_q;

  assign bus_in.rdata = sel_mem  ? mem_bus.rdata  :
                        sel_fifo ? fifo_bus.rdata : '0;

  assign bus_in.error = sel_mem  ? mem_bus.error  :
                        sel_fifo ? fifo_bus.error : err_q;

endmodule

/* rtl/ext_periph_top.sv */
// External peripheral subsystem top level
// Register bus demux, slow memory, FIFO and power-switch model
module ext_periph_top #(
  parameter int MEM_WORDS = 256,
  parameter int FIFO_DEPTH = 8,
  parameter int DOMAINS = 4,
  parameter int SWITCH_ACK_LATENCY = 15
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic reg_valid_i,
  input  logic reg_write_i,
  input  logic [ext_periph_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [ext_periph_pkg::DATA_W-1:0] reg_wdata_i,
  input  logic [ext_periph_pkg::STRB_W-1:0] reg_wstrb_i,
  output logic reg_ready_o,
  output logic [ext_periph_pkg::DATA_W-1:0] reg_rdata_o,
  output logic reg_error_o,
  output logic fifo_in_ready_o,
  output logic fifo_out_valid_o,
  output logic fifo_intr_o,
  input  logic [DOMAINS-1:0] switch_n_i,
  output logic [DOMAINS-1:0] switch_ack_n_o
);

  reg_bus_if bus_in ();
  reg_bus_if mem_bus ();
  reg_bus_if fifo_bus ();

  assign bus_in.valid = reg_valid_i;
  assign bus_in.write = reg_write_i;
  assign bus_in.addr = reg_addr_i;
  assign bus_in.wdata = reg_wdata_i;
  assign bus_in.wstrb = reg_wstrb_i;
  assign reg_ready_o = bus_in.ready;
  assign reg_rdata_o = bus_in.rdata;
  assign reg_error_o = bus_in.error;

  reg_demux reg_demux_i (
    .clk_i,
    .rst_i,
    .bus_in (bus_in.device),
    .mem_bus (mem_bus.host),
    .fifo_bus(fifo_bus.host)
  );

  slow_memory #(.MEM_WORDS(MEM_WORDS)) slow_memory_i (
    .clk_i,
    .rst_i,
    .bus(mem_bus.device)
  );

  // DMA-slot status and watermark interrupt
  iffifo #(.FIFO_DEPTH(FIFO_DEPTH)) iffifo_i (
    .clk_i,
    .rst_i,
    .bus        (fifo_bus.device),
    .in_ready_o (fifo_in_ready_o),
    .out_valid_o(fifo_out_valid_o),
    .intr_o     (fifo_intr_o)
  );

  power_switch_model #(
    .DOMAINS(DOMAINS),
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY)
  ) power_switch_model_i (
    .clk_i,
    .rst_i,
    .switch_n_i,
    .switch_ack_n_o
  );

endmodule

/* tb/ext_periph_assert.sv */
// Concurrent checks on the top-level register bus handshake
module ext_periph_assert (
  input logic clk_i,
  input logic rst_i,
  input logic valid_i,
  input logic ready_i,
  input logic error_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  ready_single_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    ready_i |=> !ready_i)
    else begin
      fail_count++;
      $error("reg_ready_o stayed high for more than one cycle");
    end

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    ready_i |-> valid_i)
    else begin
      fail_count++;
      $error("reg_ready_o high without reg_valid_i");
    end

  error_needs_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    error_i |-> ready_i)
    else begin
      fail_count++;
      $error("reg_error_o high outside a ready cycle");
    end

  // Registers settle on the first reset edge
  no_ready_in_reset: assert property (@(posedge clk_i) rst_i |=> !ready_i)
    else begin
      fail_count++;
      $error("reg_ready_o high during reset");
    end

endmodule

bind ext_periph_top ext_periph_assert assert_i (
  .clk_i  (clk_i),
  .rst_i  (rst_i),
  .valid_i(reg_valid_i),
  .ready_i(reg_ready_o),
  .error_i(reg_error_o)
);

/* tb/tb_ext_periph.sv */
// Trace-driven testbench for the external peripheral subsystem
// Register bus accesses, FIFO status, power-switch acknowledge and watchdog
module tb_ext_periph;
  timeunit 1ns;
  timeprecision 100ps;
  import ext_periph_pkg::*;

  localparam int FIFO_DEPTH = 8;
  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;
  localparam int DOMAINS = 4;
  localparam int ACK_LATENCY = 15;
  localparam int POWER_CYCLES = 200;
  localparam int MAX_WAIT = 10;
  localparam int MAX_LINES = 64;

  logic clk_i;
  logic rst_i;
  logic reg_valid_i;
  logic reg_write_i;
  logic [ADDR_W-1:0] reg_addr_i;
  logic [DATA_W-1:0] reg_wdata_i;
  logic [STRB_W-1:0] reg_wstrb_i;
  logic reg_ready_o;
  logic [DATA_W-1:0] reg_rdata_o;
  logic reg_error_o;
  logic fifo_in_ready_o;
  logic fifo_out_valid_o;
  logic fifo_intr_o;
  logic [DOMAINS-1:0] switch_n_i;
  logic [DOMAINS-1:0] switch_ack_n_o;

  string t_name [MAX_LINES];
  logic t_write [MAX_LINES];
  logic [ADDR_W-1:0] t_addr [MAX_LINES];
  logic [DATA_W-1:0] t_wdata [MAX_LINES];
  logic [STRB_W-1:0] t_wstrb [MAX_LINES];
  logic [DATA_W-1:0] t_rdata [MAX_LINES];
  logic t_error [MAX_LINES];
  int n_lines = 0;

  // FIFO state tracked from the accesses
  int fifo_level = 0;
  int fifo_wmark = 0;
  int seed;
  int tests_run = 0;
  int tests_failed = 0;
  int timeout_ns = 0;

  ext_periph_top #(
    .MEM_WORDS(256),
    .FIFO_DEPTH(FIFO_DEPTH),
    .DOMAINS(DOMAINS),
    .SWITCH_ACK_LATENCY(ACK_LATENCY)
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("watchdog expired after %0d ns, the tests did not finish", timeout_ns);
    $display("Testbench failed");
    $finish;
  end

  task automatic load_trace();
    int fd;
    int n;
    string line;
    string name;
    logic [31:0] w, a, d, s, r, e;
    fd = $fopen("tb/ext_periph_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file tb/ext_periph_trace.txt");
      tests_failed++;
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h", name, w, a, d, s, r, e);
      if (n != 7 || n_lines >= MAX_LINES) begin
        $display("trace line could not be used: %s", line);
        tests_failed++;
        continue;
      end
      t_name[n_lines] = name;
      t_write[n_lines] = w[0];
      t_addr[n_lines] = a;
      t_wdata[n_lines] = d;
      t_wstrb[n_lines] = s[STRB_W-1:0];
      t_rdata[n_lines] = r;
      t_error[n_lines] = e[0];
      n_lines++;
    end
    $fclose(fd);
  endtask

  task automatic check_bit(input string test, input string sig, input logic exp,
                           input logic act, inout logic ok);
    if (act !== exp) begin
      $display("error %s %s expected %0d actual %0d", test, sig, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic record_result(input string test, input logic ok);
    tests_run++;
    if (ok) begin
      $display("%s passed", test);
    end else begin
      tests_failed++;
      $display("%s failed", test);
    end
  endtask

  task automatic check_fifo_status(input string test, inout logic ok);
    check_bit(test, "fifo_in_ready_o", fifo_level != FIFO_DEPTH, fifo_in_ready_o, ok);
    check_bit(test, "fifo_out_valid_o", fifo_level != 0, fifo_out_valid_o, ok);
    check_bit(test, "fifo_intr_o", fifo_wmark != 0 && fifo_level >= fifo_wmark,
              fifo_intr_o, ok);
  endtask

  task automatic run_access(input int i);
    int waited;
    logic got_ready;
    logic ok;
    logic err;
    logic [DATA_W-1:0] rdata;
    periph_addr_u a;
    a.raw = t_addr[i];
    ok = 1'b1;
    got_ready = 1'b0;
    waited = 0;
    @(posedge clk_i);
    #1;
    reg_valid_i = 1'b1;
    reg_write_i = t_write[i];
    reg_addr_i = t_addr[i];
    reg_wdata_i = t_wdata[i];
    reg_wstrb_i = t_wstrb[i];
    while (!got_ready && waited < MAX_WAIT) begin
      @(negedge clk_i);
      if (reg_ready_o === 1'b1) begin
        got_ready = 1'b1;
        rdata = reg_rdata_o;
        err = reg_error_o;
      end else begin
        waited++;
      end
    end
    // Access completes on the following edge
    @(posedge clk_i);
    #1;
    reg_valid_i = 1'b0;
    if (!got_ready) begin
      $display("%s got no ready within %0d cycles", t_name[i], MAX_WAIT);
      ok = 1'b0;
    end else begin
      check_bit(t_name[i], "reg_error_o", t_error[i], err, ok);
      if (!t_write[i] && rdata !== t_rdata[i]) begin
        $display("error %s rdata expected %h actual %h", t_name[i], t_rdata[i], rdata);
        ok = 1'b0;
      end
      if (a.fld.slot == MEM_SLOT ? (waited < 1 || waited > 8) : waited != 1) begin
        $display("%s answered after %0d cycles, outside its latency", t_name[i], waited);
        ok = 1'b0;
      end
    end
    if (a.fld.slot == FIFO_SLOT) begin
      if (a.fld.offset == 0 && t_write[i] && fifo_level < FIFO_DEPTH) begin
        fifo_level++;
      end else if (a.fld.offset == 0 && !t_write[i] && fifo_level > 0) begin
        fifo_level--;
      end else if (a.fld.offset == 2 && t_write[i]) begin
        fifo_wmark = int'(t_wdata[i][LVL_W-1:0]);
      end
      check_fifo_status(t_name[i], ok);
    end
    record_result(t_name[i], ok);
  endtask

  task automatic check_reset_state();
    logic ok;
    ok = 1'b1;
    @(negedge clk_i);
    check_bit("reset_state", "reg_ready_o", 1'b0, reg_ready_o, ok);
    check_bit("reset_state", "reg_error_o", 1'b0, reg_error_o, ok);
    check_fifo_status("reset_state", ok);
    if (switch_ack_n_o !== '1) begin
      $display("error reset_state switch_ack_n_o expected %h actual %h", {DOMAINS{1'b1}},
               switch_ack_n_o);
      ok = 1'b0;
    end
    record_result("reset_state", ok);
  endtask

  task automatic run_power_test();
    logic [DOMAINS-1:0] hist [$];
    logic [DOMAINS-1:0] v;
    logic [DOMAINS-1:0] exp;
    int rnd;
    logic ok;
    ok = 1'b1;
    // Input has been all ones for longer than the pipeline
    for (int k = 0; k < ACK_LATENCY; k++) begin
      hist.push_back('1);
    end
    for (int c = 0; c < POWER_CYCLES; c++) begin
      @(posedge clk_i);
      #1;
      rnd = $random(seed);
      v = rnd[DOMAINS-1:0];
      switch_n_i = v;
      hist.push_back(v);
      @(negedge clk_i);
      exp = hist.pop_front();
      if (switch_ack_n_o !== exp) begin
        $display("error power_switch cycle %0d expected %h actual %h", c, exp, switch_ack_n_o);
        ok = 1'b0;
      end
    end
    record_result("power_switch", ok);
  endtask

  initial begin
    int assert_fails;
    seed = 11137;
    rst_i = 1'b1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    reg_wstrb_i = '0;
    switch_n_i = '1;
    load_trace();
    timeout_ns = (n_lines * 12 + POWER_CYCLES + 100) * 4;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_reset_state();
    for (int i = 0; i < n_lines; i++) begin
      run_access(i);
    end
    run_power_test();
    assert_fails = dut.assert_i.fail_count;
    $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
             tests_run, tests_run - tests_failed, tests_failed, assert_fails);
    if (tests_failed == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* ext_periph.f */
rtl/ext_periph_pkg.sv
rtl/reg_bus_if.sv
rtl/power_switch_model.sv
rtl/slow_memory.sv
rtl/iffifo.sv
rtl/reg_demux.sv
rtl/ext_periph_top.sv
tb/ext_periph_assert.sv
tb/tb_ext_periph.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ext_periph
FILELIST   := ext_periph.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/ext_periph_trace.txt */
# name write addr wdata wstrb exp_rdata exp_error, fields after the name in hex
# exp_rdata is compared on reads only
mem_wr_full_w0 1 00000000 11223344 f 00000000 0
mem_wr_bytes02_w0 1 00000000 aabbccdd 5 00000000 0
mem_wr_full_w255 1 000003fc 0badbeef f 00000000 0
mem_wr_bytes12_w255 1 000003fc 99887766 6 00000000 0
mem_rd_w0 0 00000000 00000000 0 11bb33dd 0
mem_rd_w255 0 000003fc 00000000 0 0b8877ef 0
mem_rd_wrap_w511 0 000007fc 00000000 0 0b8877ef 0
unmapped_rd 0 00002000 00000000 0 00000000 1
unmapped_wr 1 0000f010 deadbeef f 00000000 1
fifo_pop_empty 0 00001000 00000000 0 00000000 1
fifo_level_zero 0 00001004 00000000 0 00000000 0
fifo_wmark_set 1 00001008 00000003 f 00000000 0
fifo_wmark_read 0 00001008 00000000 0 00000003 0
fifo_push_0 1 00001000 a0000000 f 00000000 0
fifo_push_1 1 00001000 a0000011 f 00000000 0
fifo_push_2 1 00001000 a0000022 f 00000000 0
fifo_push_3 1 00001000 a0000033 f 00000000 0
fifo_push_4 1 00001000 a0000044 f 00000000 0
fifo_push_5 1 00001000 a0000055 f 00000000 0
fifo_push_6 1 00001000 a0000066 f 00000000 0
fifo_push_7 1 00001000 a0000077 f 00000000 0
fifo_push_full 1 00001000 ffffffff f 00000000 1
fifo_level_full 0 00001004 00000000 0 00000008 0
fifo_level_write 1 00001004 00000005 f 00000000 1
fifo_bad_offset 0 00001010 00000000 0 00000000 1
fifo_pop_0 0 00001000 00000000 0 a0000000 0
fifo_pop_1 0 00001000 00000000 0 a0000011 0
fifo_pop_2 0 00001000 00000000 0 a0000022 0
fifo_pop_3 0 00001000 00000000 0 a0000033 0
fifo_pop_4 0 00001000 00000000 0 a0000044 0
fifo_pop_5 0 00001000 00000000 0 a0000055 0
fifo_pop_6 0 00001000 00000000 0 a0000066 0
fifo_pop_7 0 00001000 00000000 0 a0000077 0
fifo_pop_empty_again 0 00001000 00000000 0 00000000 1
